// ==== Bender.yml ====
package:
  name: bus_interconnect

sources:
  - hdl/bus_pkg.sv
  - hdl/addr_map_pkg.sv
  - hdl/req_arbiter.sv
  - hdl/slave_port.sv
  - hdl/resp_router.sv
  - hdl/interconnect_top.sv
  - target: test
    files:
      - verification/tb_slave_model.sv
      - verification/tb_interconnect.sv

// ==== compile.f ====
hdl/bus_pkg.sv
hdl/addr_map_pkg.sv
hdl/req_arbiter.sv
hdl/slave_port.sv
hdl/resp_router.sv
hdl/interconnect_top.sv
verification/tb_slave_model.sv
verification/tb_interconnect.sv

// ==== hdl/addr_map_pkg.sv ====
package addr_map_pkg;

    import bus_pkg::*;

    localparam int addr_w   = 32;
    localparam int region_w = 4;
    localparam int offset_w = addr_w - region_w;

    // windows, element 0 is the rightmost entry
    localparam logic [num_slaves-1:0][addr_w-1:0] slave_start = {
        32'h1000_0000,   // register block
        32'h0000_0000    // memory window
    };

    localparam logic [num_slaves-1:0][addr_w-1:0] slave_end = {
        32'h1000_000f,
        32'h0fff_ffff
    };

    // unmapped addresses end up here
    localparam int default_slave = 0;

    // one address word, seen flat or as region/offset
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [region_w-1:0] region;
            logic [offset_w-1:0] offset;
        } win;
    } bus_addr_u;

endpackage

// ==== hdl/bus_pkg.sv ====
package bus_pkg;

    // topology
    localparam int num_masters = 4;
    localparam int num_slaves  = 2;

    // data path
    localparam int data_w = 32;
    localparam int strb_w = data_w / 8;   // byte lanes

    // id layout, slave side id = {master index, master id}
    localparam int mid_w = 2;
    localparam int sid_w = 4;

    // index widths
    localparam int midx_w    = sid_w - mid_w;
    localparam int slv_idx_w = $clog2(num_slaves);

    typedef logic [data_w-1:0] bus_word_t;

    typedef logic [mid_w-1:0] master_id_t;

    // upper bits steer the response home
    typedef logic [sid_w-1:0] ext_id_t;

    typedef logic [midx_w-1:0] master_idx_t;

endpackage

// ==== hdl/interconnect_top.sv ====
`timescale 1ns/1ps

module interconnect_top
    import bus_pkg::*;
    import addr_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    BUS_RST,

    // master request channel
    input  logic [addr_w-1:0]       m_addr    [num_masters],
    input  bus_word_t               m_wdata   [num_masters],
    input  logic [strb_w-1:0]       m_strb    [num_masters],
    input  logic [num_masters-1:0]  m_we,
    input  master_id_t              m_id      [num_masters],
    input  logic [num_masters-1:0]  m_valid,
    output logic [num_masters-1:0]  m_ready,

    // master response channel
    output bus_word_t               m_rdata   [num_masters],
    output master_id_t              m_back_id [num_masters],
    output logic [num_masters-1:0]  m_rvalid,
    input  logic [num_masters-1:0]  m_rready,

    // slave request channel
    output logic [offset_w-1:0]     s_addr    [num_slaves],
    output bus_word_t               s_wdata   [num_slaves],
    output logic [strb_w-1:0]       s_strb    [num_slaves],
    output logic [num_slaves-1:0]   s_we,
    output ext_id_t                 s_id      [num_slaves],
    output logic [num_slaves-1:0]   s_valid,
    input  logic [num_slaves-1:0]   s_ready,

    // slave response channel
    input  bus_word_t               s_rdata   [num_slaves],
    input  ext_id_t                 s_back_id [num_slaves],
    input  logic [num_slaves-1:0]   s_rvalid,
    output logic [num_slaves-1:0]   s_rready
);

    bus_addr_u             bus_addr;
    bus_word_t             bus_wdata;
    logic [strb_w-1:0]     bus_strb;
    logic                  bus_we;
    ext_id_t               bus_id;
    logic                  bus_valid;
    logic [num_slaves-1:0] sel_ready;

    req_arbiter u_arb (
        .clk       (clk),
        .BUS_RST   (BUS_RST),
        .m_addr    (m_addr),
        .m_wdata   (m_wdata),
        .m_strb    (m_strb),
        .m_we      (m_we),
        .m_id      (m_id),
        .m_valid   (m_valid),
        .m_ready   (m_ready),
        .sel_ready (sel_ready),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_strb  (bus_strb),
        .bus_we    (bus_we),
        .bus_id    (bus_id),
        .bus_valid (bus_valid)
    );

    // one request port per slave window
    for (genvar i = 0; i < num_slaves; i++) begin : g_port
        slave_port #(
            .slave_num (i)
        ) u_port (
            .clk       (clk),
            .BUS_RST   (BUS_RST),
            .bus_addr  (bus_addr),
            .bus_wdata (bus_wdata),
            .bus_strb  (bus_strb),
            .bus_we    (bus_we),
            .bus_id    (bus_id),
            .bus_valid (bus_valid),
            .sel_ready (sel_ready[i]),
            .s_addr    (s_addr[i]),
            .s_wdata   (s_wdata[i]),
            .s_strb    (s_strb[i]),
            .s_we      (s_we[i]),
            .s_id      (s_id[i]),
            .s_valid   (s_valid[i]),
            .s_ready   (s_ready[i])
        );
    end

    resp_router u_rsp (
        .clk       (clk),
        .BUS_RST   (BUS_RST),
        .s_rdata   (s_rdata),
        .s_back_id (s_back_id),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_rdata   (m_rdata),
        .m_back_id (m_back_id),
        .m_rvalid  (m_rvalid),
        .m_rready  (m_rready)
    );

endmodule

// ==== hdl/req_arbiter.sv ====
`timescale 1ns/1ps

module req_arbiter
    import bus_pkg::*;
    import addr_map_pkg::*;
(
    input  logic                    clk,
    input  logic                    BUS_RST,

    // master request side
    input  logic [addr_w-1:0]       m_addr  [num_masters],
    input  bus_word_t               m_wdata [num_masters],
    input  logic [strb_w-1:0]       m_strb  [num_masters],
    input  logic [num_masters-1:0]  m_we,
    input  master_id_t              m_id    [num_masters],
    input  logic [num_masters-1:0]  m_valid,
    output logic [num_masters-1:0]  m_ready,

    // one bit per slave port, already qualified by its window match
    input  logic [num_slaves-1:0]   sel_ready,

    // shared internal bus
    output bus_addr_u               bus_addr,
    output bus_word_t               bus_wdata,
    output logic [strb_w-1:0]       bus_strb,
    output logic                    bus_we,
    output ext_id_t                 bus_id,
    output logic                    bus_valid
);

    master_idx_t grant;
    master_idx_t grant_nxt;
    logic        bus_ready;
    logic        bus_hs;

    // only the claiming port can be ready
    assign bus_ready = |sel_ready;
    assign bus_hs    = bus_valid & bus_ready;

    // fixed priority, re-arbitrate only when idle or on handshake
    always_comb begin
        grant_nxt = grant;
        if (!bus_valid || bus_hs) begin
            grant_nxt = '0;
            for (int i = num_masters - 1; i >= 0; i--) begin
                if (m_valid[i]) begin
                    grant_nxt = master_idx_t'(i);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (BUS_RST) begin
            grant <= '0;
        end else begin
            grant <= grant_nxt;
        end
    end

    // granted master onto the bus
    always_comb begin
        bus_addr.raw = m_addr[grant];
        bus_wdata    = m_wdata[grant];
        bus_strb     = m_strb[grant];
        bus_we       = m_we[grant];
        bus_valid    = m_valid[grant];
        bus_id       = {grant, m_id[grant]};   // master index prefix
    end

    always_comb begin
        for (int i = 0; i < num_masters; i++) begin
            m_ready[i] = bus_valid && bus_ready && (grant == master_idx_t'(i));
        end
    end

endmodule

// ==== hdl/resp_router.sv ====
`timescale 1ns/1ps

module resp_router
    import bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    BUS_RST,

    // slave response side
    input  bus_word_t               s_rdata   [num_slaves],
    input  ext_id_t                 s_back_id [num_slaves],
    input  logic [num_slaves-1:0]   s_rvalid,
    output logic [num_slaves-1:0]   s_rready,

    // master response side
    output bus_word_t               m_rdata   [num_masters],
    output master_id_t              m_back_id [num_masters],
    output logic [num_masters-1:0]  m_rvalid,
    input  logic [num_masters-1:0]  m_rready
);

    logic [slv_idx_w-1:0] cur_sel;
    logic [slv_idx_w-1:0] pick;
    logic                 locked;
    logic                 rsp_valid;
    ext_id_t              rsp_id;
    master_idx_t          target;
    logic                 rsp_hs;

    // slave 0 wins unless a choice is already held
    always_comb begin
        pick = cur_sel;
        if (!locked) begin
            pick = '0;
            for (int i = num_slaves - 1; i >= 0; i--) begin
                if (s_rvalid[i]) begin
                    pick = slv_idx_w'(i);
                end
            end
        end
    end

    assign rsp_valid = s_rvalid[pick];
    assign rsp_id    = s_back_id[pick];
    assign target    = rsp_id[sid_w-1:mid_w];
    assign rsp_hs    = rsp_valid && m_rready[target];

    always_ff @(posedge clk) begin
        if (BUS_RST) begin
            locked  <= 1'b0;
            cur_sel <= '0;
        end else begin
            cur_sel <= pick;
            if (rsp_hs) begin
                locked <= 1'b0;
            end else if (rsp_valid) begin
                locked <= 1'b1;   // stalled by the master, hold on
            end
        end
    end

    always_comb begin
        for (int j = 0; j < num_slaves; j++) begin
            s_rready[j] = rsp_hs && (pick == slv_idx_w'(j));
        end
    end

    // data is broadcast, valid goes to one master only
    always_comb begin
        for (int i = 0; i < num_masters; i++) begin
            m_rdata[i]   = s_rdata[pick];
            m_back_id[i] = rsp_id[mid_w-1:0];
            m_rvalid[i]  = rsp_valid && (target == master_idx_t'(i));
        end
    end

endmodule

// ==== hdl/slave_port.sv ====
`timescale 1ns/1ps

module slave_port
    import bus_pkg::*;
    import addr_map_pkg::*;
#(
    parameter int slave_num = 0
)(
    input  logic                clk,
    input  logic                BUS_RST,

    // shared bus from the arbiter
    input  bus_addr_u           bus_addr,
    input  bus_word_t           bus_wdata,
    input  logic [strb_w-1:0]   bus_strb,
    input  logic                bus_we,
    input  ext_id_t             bus_id,
    input  logic                bus_valid,
    output logic                sel_ready,

    // request toward the slave
    output logic [offset_w-1:0] s_addr,
    output bus_word_t           s_wdata,
    output logic [strb_w-1:0]   s_strb,
    output logic                s_we,
    output ext_id_t             s_id,
    output logic                s_valid,
    input  logic                s_ready
);

    logic [num_slaves-1:0] hit;
    logic                  claim;
    logic                  accept;
    bus_addr_u             rel_addr;

    // window compare against every slave
    always_comb begin
        for (int i = 0; i < num_slaves; i++) begin
            hit[i] = (bus_addr.raw >= slave_start[i]) && (bus_addr.raw <= slave_end[i]);
        end
    end

    // default slave picks up anything unmapped
    assign claim = hit[slave_num] || ((slave_num == default_slave) && (hit == '0));

    // free entry, or the held one leaves on this edge
    assign sel_ready = claim && (!s_valid || s_ready);
    assign accept    = bus_valid && sel_ready;

    assign rel_addr.raw = bus_addr.raw - slave_start[slave_num];

    always_ff @(posedge clk) begin
        if (BUS_RST) begin
            s_valid <= 1'b0;
        end else if (accept) begin
            s_valid <= 1'b1;
        end else if (s_ready) begin
            s_valid <= 1'b0;
        end
    end

    // payload, loaded on accept only
    always_ff @(posedge clk) begin
        if (accept) begin
            s_addr  <= rel_addr.win.offset;   // region bits dropped
            s_wdata <= bus_wdata;
            s_strb  <= bus_strb;
            s_we    <= bus_we;
            s_id    <= bus_id;
        end
    end

endmodule

// ==== verification/tb_interconnect.sv ====
`timescale 1ns/1ps

module tb_interconnect
    import bus_pkg::*;
    import addr_map_pkg::*;
();

    localparam int max_tests = 24;

    logic                   clk;
    logic                   BUS_RST;
    logic [addr_w-1:0]      m_addr    [num_masters];
    bus_word_t              m_wdata   [num_masters];
    logic [strb_w-1:0]      m_strb    [num_masters];
    logic [num_masters-1:0] m_we;
    master_id_t             m_id      [num_masters];
    logic [num_masters-1:0] m_valid;
    logic [num_masters-1:0] m_ready;
    bus_word_t              m_rdata   [num_masters];
    master_id_t             m_back_id [num_masters];
    logic [num_masters-1:0] m_rvalid;
    logic [num_masters-1:0] m_rready;
    logic [offset_w-1:0]    s_addr    [num_slaves];
    bus_word_t              s_wdata   [num_slaves];
    logic [strb_w-1:0]      s_strb    [num_slaves];
    logic [num_slaves-1:0]  s_we;
    ext_id_t                s_id      [num_slaves];
    logic [num_slaves-1:0]  s_valid;
    logic [num_slaves-1:0]  s_ready;
    bus_word_t              s_rdata   [num_slaves];
    ext_id_t                s_back_id [num_slaves];
    logic [num_slaves-1:0]  s_rvalid;
    logic [num_slaves-1:0]  s_rready;

    string                  t_name  [max_tests];
    int                     t_mst   [max_tests];
    logic [num_masters-1:0] t_mask  [max_tests];   // more masters raising valid together
    logic [addr_w-1:0]      t_addr  [max_tests];
    bus_word_t              t_wdata [max_tests];
    logic [strb_w-1:0]      t_strb  [max_tests];
    logic                   t_we    [max_tests];
    master_id_t             t_id    [max_tests];
    int                     n_tests = 0;

    bus_word_t              shadow   [logic [offset_w:0]];   // {slave, offset}
    bus_word_t              exp_data [num_masters];
    int                     exp_sl   [num_masters];
    logic [offset_w-1:0]    exp_off  [num_masters];
    int                     cycles = 0;
    int                     errs = 0;
    int                     n_pass = 0;
    int                     n_fail = 0;
    integer                 seed;

    interconnect_top dut0 (.*);

    // memory model on slave 0 and register file on slave 1
    for (genvar i = 0; i < num_slaves; i++) begin : g_slv
        tb_slave_model #(.reg_file(i == 1)) u_model (
            .clk       (clk),
            .BUS_RST   (BUS_RST),
            .s_addr    (s_addr[i]),
            .s_wdata   (s_wdata[i]),
            .s_strb    (s_strb[i]),
            .s_we      (s_we[i]),
            .s_id      (s_id[i]),
            .s_valid   (s_valid[i]),
            .s_ready   (s_ready[i]),
            .s_rdata   (s_rdata[i]),
            .s_back_id (s_back_id[i]),
            .s_rvalid  (s_rvalid[i]),
            .s_rready  (s_rready[i])
        );
    end

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        wait (n_tests > 0 && cycles >= n_tests * 40);
        $display("run timed out after %0d cycles, a transfer never completed", cycles);
        $display("Something failed");
        $finish;
    end

    task automatic add_test(input string name, input int mst, input logic [3:0] mask,
                            input logic [31:0] addr, input bus_word_t wdata,
                            input logic [3:0] strb, input logic we, input master_id_t id);
        t_name[n_tests]  = name;
        t_mst[n_tests]   = mst;
        t_mask[n_tests]  = mask;
        t_addr[n_tests]  = addr;
        t_wdata[n_tests] = wdata;
        t_strb[n_tests]  = strb;
        t_we[n_tests]    = we;
        t_id[n_tests]    = id;
        n_tests++;
    endtask

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_id(input string name, input master_id_t exp, input master_id_t act);
        if (act !== exp) begin
            $display("Error %s: expected id %h, got %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_master(input string name, input master_idx_t exp,
                                input master_idx_t act);
        if (act !== exp) begin
            $display("Error %s: expected master %0d, got %0d", name, exp, act);
            errs++;
        end
    endtask

    task automatic end_test(input string name);
        if (errs == 0) begin
            n_pass++;
            $display("test %s passed", name);
        end else begin
            n_fail++;
            $display("test %s had %0d mismatches", name, errs);
        end
        errs = 0;
    endtask

    initial begin
        logic [num_masters-1:0] act;
        logic [num_masters-1:0] pend_req;
        logic [num_masters-1:0] pend_rsp;
        logic [num_masters-1:0] hs_req;
        logic [num_masters-1:0] hs_rsp;
        logic [offset_w:0]      key;
        bus_word_t              w;
        ext_id_t                got_id;
        logic [offset_w-1:0]    got_off;
        int                     rd_ptr [num_slaves];
        int                     first_hs;
        int                     first_sv;

        seed     = 32'h71a8adc3;
        first_hs = -1;
        first_sv = -1;
        rd_ptr   = '{default: 0};
        BUS_RST  = 1'b1;
        m_valid  = '0;
        m_we     = '0;
        m_rready = '0;
        for (int i = 0; i < num_masters; i++) begin
            m_addr[i]  = '0;
            m_wdata[i] = '0;
            m_strb[i]  = '0;
            m_id[i]    = '0;
        end

        add_test("m0_wr_mem",   0, 4'b0000, 32'h0000_0100, 32'hdead_beef, 4'hf, 1'b1, 2'd1);
        add_test("m1_wr_mem",   1, 4'b0000, 32'h0000_0104, 32'h1234_5678, 4'hf, 1'b1, 2'd2);
        add_test("m2_wr_mem",   2, 4'b0000, 32'h0000_0108, 32'hcafe_f00d, 4'h5, 1'b1, 2'd3);
        add_test("m3_wr_mem",   3, 4'b0000, 32'h0000_010c, 32'h0bad_f00d, 4'hf, 1'b1, 2'd0);
        add_test("m0_rd_mem",   0, 4'b0000, 32'h0000_0100, 32'h0,         4'h0, 1'b0, 2'd2);
        add_test("m1_rd_mem",   1, 4'b0000, 32'h0000_0104, 32'h0,         4'h0, 1'b0, 2'd3);
        add_test("m2_rd_mem",   2, 4'b0000, 32'h0000_0108, 32'h0,         4'h0, 1'b0, 2'd0);
        add_test("m3_rd_mem",   3, 4'b0000, 32'h0000_010c, 32'h0,         4'h0, 1'b0, 2'd1);
        add_test("m2_wr_part",  2, 4'b0000, 32'h0000_0100, 32'h55aa_55aa, 4'h6, 1'b1, 2'd1);
        add_test("m1_rd_part",  1, 4'b0000, 32'h0000_0100, 32'h0,         4'h0, 1'b0, 2'd0);
        add_test("m1_wr_reg1",  1, 4'b0000, 32'h1000_0004, 32'ha5a5_0001, 4'hf, 1'b1, 2'd2);
        add_test("m3_wr_reg3",  3, 4'b0000, 32'h1000_000c, 32'h5a5a_0003, 4'hc, 1'b1, 2'd3);
        add_test("m0_rd_reg1",  0, 4'b0000, 32'h1000_0004, 32'h0,         4'h0, 1'b0, 2'd1);
        add_test("m2_rd_reg3",  2, 4'b0000, 32'h1000_000c, 32'h0,         4'h0, 1'b0, 2'd0);
        add_test("all_wr_mem",  0, 4'b1111, 32'h0000_0200, 32'h1111_0000, 4'hf, 1'b1, 2'd0);
        add_test("all_rd_mem",  0, 4'b1111, 32'h0000_0200, 32'h0,         4'h0, 1'b0, 2'd1);
        add_test("all_wr_mix",  0, 4'b1111, 32'h1000_0000, 32'h2222_0000, 4'hf, 1'b1, 2'd2);
        add_test("all_rd_mix",  0, 4'b1111, 32'h1000_0000, 32'h0,         4'h0, 1'b0, 2'd3);
        add_test("m2_wr_unmap", 2, 4'b0000, 32'h2000_0010, 32'h7777_8888, 4'h3, 1'b1, 2'd1);
        add_test("m3_rd_unmap", 3, 4'b0000, 32'h2000_0010, 32'h0,         4'h0, 1'b0, 2'd2);

        // control outputs quiet in and right after reset
        @(posedge clk);
        @(negedge clk);
        check_word("reset_idle", '0, bus_word_t'({m_ready, m_rvalid, s_valid, s_rready}));
        @(posedge clk);
        #1;
        BUS_RST = 1'b0;
        @(negedge clk);
        check_word("reset_idle", '0, bus_word_t'({m_ready, m_rvalid, s_valid, s_rready}));
        end_test("reset_idle");
        @(posedge clk);
        #1;
        m_rready = '1;

        for (int t = 0; t < n_tests; t++) begin
            act = t_mask[t] | num_masters'(1 << t_mst[t]);
            for (int i = 0; i < num_masters; i++) begin
                if (act[i]) begin
                    m_addr[i]  = t_addr[t] + 16 * (i - t_mst[t]);
                    m_wdata[i] = t_wdata[t] + (i - t_mst[t]);
                    m_strb[i]  = t_strb[t];
                    m_we[i]    = t_we[t];
                    m_id[i]    = master_id_t'(t_id[t] + i - t_mst[t]);
                    if (m_addr[i] >= 32'h1000_0000 && m_addr[i] <= 32'h1000_000f) begin
                        exp_sl[i]  = 1;   // register window
                        exp_off[i] = offset_w'(m_addr[i] - 32'h1000_0000);
                    end else begin
                        exp_sl[i]  = 0;   // memory window and anything unmapped
                        exp_off[i] = m_addr[i][offset_w-1:0];
                    end
                    key         = {exp_sl[i][0], exp_off[i]};
                    exp_data[i] = shadow.exists(key) ? shadow[key] : '0;
                    w           = exp_data[i];
                    for (int b = 0; b < strb_w; b++) begin
                        if (t_we[t] && t_strb[t][b]) begin
                            w[8*b +: 8] = m_wdata[i][8*b +: 8];
                        end
                    end
                    shadow[key] = w;
                end
            end
            m_valid  = act;
            pend_req = act;
            pend_rsp = act;
            while (pend_req != 0 || pend_rsp != 0) begin
                @(negedge clk);
                hs_req = m_valid & m_ready;
                hs_rsp = m_rvalid & m_rready;
                if (first_hs < 0 && hs_req != 0) begin
                    first_hs = cycles;
                end
                if (first_sv < 0 && s_valid != 0) begin
                    first_sv = cycles;
                end
                for (int i = 0; i < num_masters; i++) begin
                    if (m_rvalid[i] && !pend_rsp[i]) begin
                        $display("%s: response at master %0d with nothing outstanding",
                                 t_name[t], i);
                        errs++;
                    end
                    if (hs_rsp[i]) begin
                        check_id(t_name[t], m_id[i], m_back_id[i]);
                        if (!t_we[t]) begin
                            check_word(t_name[t], exp_data[i], m_rdata[i]);
                        end
                    end
                end
                pend_req &= ~hs_req;
                pend_rsp &= ~hs_rsp;
                @(posedge clk);
                #1;
                m_valid &= ~hs_req;
                m_rready = num_masters'($random(seed) | $random(seed));
            end
            // arrival order per slave follows master priority
            for (int i = 0; i < num_masters; i++) begin
                if (act[i]) begin
                    got_id  = (exp_sl[i] == 0) ? g_slv[0].u_model.id_log[rd_ptr[0]]
                                               : g_slv[1].u_model.id_log[rd_ptr[1]];
                    got_off = (exp_sl[i] == 0) ? g_slv[0].u_model.off_log[rd_ptr[0]]
                                               : g_slv[1].u_model.off_log[rd_ptr[1]];
                    rd_ptr[exp_sl[i]]++;
                    check_master(t_name[t], master_idx_t'(i), got_id[sid_w-1:mid_w]);
                    check_word(t_name[t], bus_word_t'(exp_off[i]), bus_word_t'(got_off));
                end
            end
            end_test(t_name[t]);
        end

        check_word("first_latency", 1, bus_word_t'(first_sv - first_hs));
        end_test("first_latency");

        $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verification/tb_slave_model.sv ====
`timescale 1ns/1ps

module tb_slave_model
    import bus_pkg::*;
    import addr_map_pkg::*;
#(
    parameter bit reg_file = 0
)(
    input  logic                clk,
    input  logic                BUS_RST,
    input  logic [offset_w-1:0] s_addr,
    input  bus_word_t           s_wdata,
    input  logic [strb_w-1:0]   s_strb,
    input  logic                s_we,
    input  ext_id_t             s_id,
    input  logic                s_valid,
    output logic                s_ready,
    output bus_word_t           s_rdata,
    output ext_id_t             s_back_id,
    output logic                s_rvalid,
    input  logic                s_rready
);

    bus_word_t           mem [logic [offset_w-1:0]];
    ext_id_t             id_log  [256];   // arrival order, read by the testbench
    logic [offset_w-1:0] off_log [256];
    int                  n_log;
    integer              seed;
    logic                go;
    logic [offset_w-1:0] key;

    initial seed = 32'h71a8adc3;

    // one outstanding response at a time
    assign s_ready = go && !s_rvalid;
    assign key     = reg_file ? offset_w'(s_addr[3:2]) : offset_w'(s_addr[offset_w-1:2]);

    always @(posedge clk) begin
        bus_word_t w;
        if (BUS_RST) begin
            go       <= 1'b0;
            s_rvalid <= 1'b0;
            n_log    <= 0;
        end else begin
            go <= ($random(seed) & 3) != 0;   // about one stall in four
            if (s_rvalid && s_rready) begin
                s_rvalid <= 1'b0;
            end
            if (s_valid && s_ready) begin
                w = mem.exists(key) ? mem[key] : '0;
                for (int b = 0; b < strb_w; b++) begin
                    if (s_we && s_strb[b]) begin
                        w[8*b +: 8] = s_wdata[8*b +: 8];
                    end
                end
                mem[key]       = w;
                s_rdata        <= w;
                s_back_id      <= s_id;
                s_rvalid       <= 1'b1;
                id_log[n_log]  <= s_id;
                off_log[n_log] <= s_addr;
                n_log          <= n_log + 1;
            end
        end
    end

endmodule
